/* common/norflash_pkg.sv */
// ##########################################################
// shared constants for the 8-bit NOR flash read bridge.
// timing assumes a fixed access time; no flash commands.
// FLASH_WAIT must fit in FLASH_WAIT_WIDTH bits.
// ##########################################################

package norflash_pkg;

	// ##########################################################
	// flash geometry
	// ##########################################################

	// byte address width, 4 MiB reachable.
	localparam int FLASH_ADR_WIDTH = 22;

	// swaps the two bytes of each flash halfword when set.
	localparam bit FLASH_SWAP_BYTES = 1'b0;

	// ##########################################################
	// access timing
	// ##########################################################

	// terminal wait count, one byte read lasts FLASH_WAIT+1 cycles.
	localparam int FLASH_WAIT       = 12;
	localparam int FLASH_WAIT_WIDTH = 4;

	// start edge to ack, four byte reads plus the ack cycle.
	localparam int ACK_LATENCY = 4 * (FLASH_WAIT + 1) + 1;

	// sequencer states.
	typedef enum logic [1:0] {
		FETCH_IDLE = 2'd0,
		FETCH_WAIT = 2'd1,
		FETCH_ACK  = 2'd2
	} fetch_state_t;

	// byte position in a word, 0 is the most significant lane.
	typedef logic [1:0] byte_idx_t;

endpackage

/* rtl/flash_req_decode.sv */
// ##########################################################
// word address register and flash byte address forming.
// bus address is a byte address; bits 1:0 are ignored.
// address bits above FLASH_ADR_WIDTH-1 are not checked.
// ##########################################################

module flash_req_decode
	import norflash_pkg::*;
(
	input  logic                       sys_clk,

	// bus request side.
	input  logic [31:0]                wb_adr_i,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,

	// current byte from the sequencer.
	input  byte_idx_t                  byte_idx_i,

	// flash address pins.
	output logic [FLASH_ADR_WIDTH-1:0] flash_adr_o
);

	// ##########################################################
	// word address register
	// ##########################################################

	// word part of the flash address.
	logic [FLASH_ADR_WIDTH-3:0] word_adr;

	// request seen this cycle.
	logic req;

	assign req = wb_cyc_i & wb_stb_i;

	// load only while a request is present.
	// keeps the flash pins quiet between reads.
	// payload register, no reset needed.
	always_ff @(posedge sys_clk) begin
		if (req) begin
			word_adr <= wb_adr_i[FLASH_ADR_WIDTH-1:2];
		end
	end

	// ##########################################################
	// byte address
	// ##########################################################

	// low bit optionally inverted for halfword byte swap.
	logic adr_lsb;

	assign adr_lsb = byte_idx_i[0] ^ FLASH_SWAP_BYTES;

	// word part, then byte index.
	assign flash_adr_o = {word_adr, byte_idx_i[1], adr_lsb};

endmodule

/* rtl/flash_fetch/flash_fetch_execute.sv */
// ##########################################################
// read sequencer: four byte reads then a one-cycle ack.
// each byte waits FLASH_WAIT+1 cycles, no early finish.
// no back-pressure; held strobes restart after ack.
// ##########################################################

module flash_fetch_execute
	import norflash_pkg::*;
(
	input  logic      sys_clk,
	input  logic      sys_rst,

	// bus strobes.
	input  logic      wb_cyc_i,
	input  logic      wb_stb_i,

	// byte sequencing.
	output byte_idx_t byte_idx_o,
	output logic      load_o,

	// bus acknowledge, single cycle.
	output logic      wb_ack_o
);

	// terminal count in counter width.
	localparam logic [FLASH_WAIT_WIDTH-1:0] WAIT_LAST = FLASH_WAIT_WIDTH'(FLASH_WAIT);

	// ##########################################################
	// state and counters
	// ##########################################################

	fetch_state_t                state_q;
	fetch_state_t                state_d;

	// access-time counter.
	logic [FLASH_WAIT_WIDTH-1:0] wait_cnt;
	logic                        wait_done;

	// byte within the word.
	byte_idx_t                   byte_idx_q;

	// request present.
	logic                        req;

	assign req       = wb_cyc_i & wb_stb_i;
	assign wait_done = (wait_cnt == WAIT_LAST);

	// state register.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			state_q <= FETCH_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	// counter runs only in FETCH_WAIT.
	// wraps to zero at the terminal count.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			wait_cnt <= '0;
		end else if ((state_q == FETCH_WAIT) && !wait_done) begin
			wait_cnt <= wait_cnt + 1'b1;
		end else begin
			wait_cnt <= '0;
		end
	end

	// byte index.
	// held at 0 while idle, steps on each load.
	// wraps to 0 after the fourth byte.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			byte_idx_q <= '0;
		end else if (state_q == FETCH_IDLE) begin
			byte_idx_q <= '0;
		end else if (load_o) begin
			byte_idx_q <= byte_idx_q + 1'b1;
		end
	end

	// ##########################################################
	// next state and strobes
	// ##########################################################

	// load in the terminal wait cycle only.
	assign load_o = (state_q == FETCH_WAIT) && wait_done;

	// ack decoded straight from the state register.
	assign wb_ack_o = (state_q == FETCH_ACK);

	assign byte_idx_o = byte_idx_q;

	always_comb begin
		state_d = state_q;
		case (state_q)
			// wait for cyc and stb together.
			FETCH_IDLE: begin
				if (req) begin
					state_d = FETCH_WAIT;
				end
			end

			// last byte loaded, word complete.
			FETCH_WAIT: begin
				if (wait_done && (byte_idx_q == 2'd3)) begin
					state_d = FETCH_ACK;
				end
			end

			// one ack cycle, then idle.
			FETCH_ACK: begin
				state_d = FETCH_IDLE;
			end

			// unused encoding.
			default: begin
				state_d = FETCH_IDLE;
			end
		endcase
	end

endmodule

/* rtl/flash_word_result.sv */
// ##########################################################
// 32-bit read data register, one byte lane per load.
// lane 0 is bits 31:24 (big-endian lane order).
// contents undefined until the first load.
// ##########################################################

module flash_word_result
	import norflash_pkg::*;
(
	input  logic        sys_clk,

	// flash data pins.
	input  logic [7:0]  flash_d_i,

	// load strobe and target lane.
	input  logic        load_i,
	input  byte_idx_t   byte_idx_i,

	// assembled word, held until next load.
	output logic [31:0] wb_dat_o
);

	// ##########################################################
	// lane writes
	// ##########################################################

	// only the addressed lane changes.
	// others keep their value.
	always_ff @(posedge sys_clk) begin
		if (load_i) begin
			case (byte_idx_i)
				// first byte, top lane.
				2'd0: begin
					wb_dat_o[31:24] <= flash_d_i;
				end
				2'd1: begin
					wb_dat_o[23:16] <= flash_d_i;
				end
				2'd2: begin
					wb_dat_o[15:8] <= flash_d_i;
				end
				// last byte, bottom lane.
				2'd3: begin
					wb_dat_o[7:0] <= flash_d_i;
				end
				default: begin
					wb_dat_o <= wb_dat_o;
				end
			endcase
		end
	end

endmodule

/* rtl/norflash8_top.sv */
// ##########################################################
// read-only bus bridge to an 8-bit parallel NOR flash.
// reads only; no writes, erase, bursts or byte selects.
// ack comes ACK_LATENCY cycles after the request edge.
// ##########################################################

module norflash8_top
	import norflash_pkg::*;
(
	input  logic                       sys_clk,
	input  logic                       sys_rst,

	// bus slave port.
	input  logic [31:0]                wb_adr_i,
	input  logic                       wb_cyc_i,
	input  logic                       wb_stb_i,
	output logic [31:0]                wb_dat_o,
	output logic                       wb_ack_o,

	// flash pins.
	output logic [FLASH_ADR_WIDTH-1:0] flash_adr_o,
	input  logic [7:0]                 flash_d_i
);

	// ##########################################################
	// internal wires
	// ##########################################################

	// current byte, shared by decode and result.
	byte_idx_t byte_idx;

	// byte sample strobe.
	logic      load;

	// address decode.
	flash_req_decode flash_req_decode_inst (
		.sys_clk     (sys_clk),
		.wb_adr_i    (wb_adr_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.byte_idx_i  (byte_idx),
		.flash_adr_o (flash_adr_o)
	);

	// sequencer and wait counter.
	flash_fetch_execute flash_fetch_execute_inst (
		.sys_clk    (sys_clk),
		.sys_rst    (sys_rst),
		.wb_cyc_i   (wb_cyc_i),
		.wb_stb_i   (wb_stb_i),
		.byte_idx_o (byte_idx),
		.load_o     (load),
		.wb_ack_o   (wb_ack_o)
	);

	// byte lane assembly.
	flash_word_result flash_word_result_inst (
		.sys_clk    (sys_clk),
		.flash_d_i  (flash_d_i),
		.load_i     (load),
		.byte_idx_i (byte_idx),
		.wb_dat_o   (wb_dat_o)
	);

endmodule

/* testbench/flash_model.sv */
// ##########################################################
// behavioral 8-bit NOR flash, read only.
// byte content follows a fixed rule of the address.
// drives 8'hEE until the address has been stable 12 cycles.
// ##########################################################

module flash_model
	import norflash_pkg::*;
(
	input  logic                       sys_clk,
	input  logic                       sys_rst,

	// address from the bridge.
	input  logic [FLASH_ADR_WIDTH-1:0] flash_adr_i,

	// data back to the bridge.
	output logic [7:0]                 flash_d_o
);

	// access time of the part, in cycles.
	localparam int STABLE_CYCLES = 12;

	// address seen at the last edge.
	logic [FLASH_ADR_WIDTH-1:0] adr_q;

	// cycles the address has been held.
	int                         stable_cnt;

	// restart the count on any address change.
	// saturates once the access time is covered.
	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			adr_q      <= '0;
			stable_cnt <= 0;
		end else if (flash_adr_i !== adr_q) begin
			adr_q      <= flash_adr_i;
			stable_cnt <= 1;
		end else if (stable_cnt < STABLE_CYCLES) begin
			stable_cnt <= stable_cnt + 1;
		end
	end

	// content rule: (a * 37 + 5) xor (a >> 8), low byte.
	function automatic logic [7:0] flash_byte(input logic [FLASH_ADR_WIDTH-1:0] adr);
		int a;
		a = int'(adr);
		return 8'((a * 37 + 5) ^ (a >> 8));
	endfunction

	// poison until the access time has passed.
	assign flash_d_o = ((stable_cnt >= STABLE_CYCLES) && (flash_adr_i === adr_q)) ?
		flash_byte(flash_adr_i) : 8'hEE;

endmodule

/* testbench/norflash8_assert.sv */
// ##########################################################
// concurrent checks on the read sequencer.
// bound into every flash_fetch_execute instance.
// all checks are off while sys_rst is high.
// ##########################################################

module norflash8_assert
	import norflash_pkg::*;
(
	input  logic         sys_clk,
	input  logic         sys_rst,

	// sequencer internals.
	input  fetch_state_t state_i,
	input  logic         load_i,
	input  byte_idx_t    byte_idx_i,

	// bus acknowledge.
	input  logic         wb_ack_i
);

	// ack is a single-cycle pulse.
	ack_single_pulse: assert property (@(posedge sys_clk) disable iff (sys_rst)
		wb_ack_i |=> !wb_ack_i)
		else $error("wb_ack_o high for two consecutive cycles");

	// bytes are sampled only while waiting.
	load_only_in_wait: assert property (@(posedge sys_clk) disable iff (sys_rst)
		load_i |-> (state_i == FETCH_WAIT))
		else $error("load_o high outside FETCH_WAIT");

	// byte index, and so the flash address, holds during each wait.
	byte_idx_hold: assert property (@(posedge sys_clk) disable iff (sys_rst)
		((state_i == FETCH_WAIT) && !load_i) |=> $stable(byte_idx_i))
		else $error("flash byte address moved before its byte was sampled");

endmodule

bind flash_fetch_execute norflash8_assert norflash8_assert_inst (
	.sys_clk    (sys_clk),
	.sys_rst    (sys_rst),
	.state_i    (state_q),
	.load_i     (load_o),
	.byte_idx_i (byte_idx_o),
	.wb_ack_i   (wb_ack_o)
);

/* testbench/tb_norflash8.sv */
// ##########################################################
// testbench for the NOR flash read bridge.
// requests and expected words come from a data file.
// expected words assume FLASH_SWAP_BYTES is 0.
// ##########################################################

module tb_norflash8
	import norflash_pkg::*;
();

	logic                       sys_clk;
	logic                       sys_rst;
	logic [31:0]                wb_adr_i;
	logic                       wb_cyc_i;
	logic                       wb_stb_i;
	logic [31:0]                wb_dat_o;
	logic                       wb_ack_o;
	logic [FLASH_ADR_WIDTH-1:0] flash_adr;
	logic [7:0]                 flash_d;

	// requests from the data file.
	logic [31:0]                req_adr[$];
	int                         req_gap[$];
	logic [31:0]                req_data[$];

	int                         cycle_cnt     = 0;
	int                         timeout_limit = 0;

	// 40 unit clock.
	always #20 sys_clk = ~sys_clk;

	norflash8_top norflash8_top_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.wb_adr_i    (wb_adr_i),
		.wb_cyc_i    (wb_cyc_i),
		.wb_stb_i    (wb_stb_i),
		.wb_dat_o    (wb_dat_o),
		.wb_ack_o    (wb_ack_o),
		.flash_adr_o (flash_adr),
		.flash_d_i   (flash_d)
	);

	flash_model flash_model_inst (
		.sys_clk     (sys_clk),
		.sys_rst     (sys_rst),
		.flash_adr_i (flash_adr),
		.flash_d_o   (flash_d)
	);

	// ##########################################################
	// checks
	// ##########################################################

	task automatic stop_run();
		$display("FAIL: see errors above");
		$fatal(1, "simulation stopped on first error");
	endtask

	task automatic check_word(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			$display("error: time %0t, signal wb_dat_o, expected %08h, actual %08h",
				$time, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_latency(input int expected, input int actual);
		if (actual != expected) begin
			$display("error: time %0t, signal wb_ack_o latency, expected %0d, actual %0d",
				$time, expected, actual);
			stop_run();
		end
	endtask

	task automatic check_flash_adr(input logic [FLASH_ADR_WIDTH-1:0] expected,
		input logic [FLASH_ADR_WIDTH-1:0] actual);
		if (actual !== expected) begin
			$display("error: time %0t, signal flash_adr_o, expected %06h, actual %06h",
				$time, expected, actual);
			stop_run();
		end
	endtask

	task automatic compare_ack(input logic expected, input logic actual);
		if (actual !== expected) begin
			$display("error: time %0t, signal wb_ack_o, expected %b, actual %b",
				$time, expected, actual);
			stop_run();
		end
	endtask

	// limit from the number of requests.
	always @(posedge sys_clk) begin
		cycle_cnt <= cycle_cnt + 1;
		if ((timeout_limit > 0) && (cycle_cnt > timeout_limit)) begin
			$display("timeout after %0d cycles, a read never completed", cycle_cnt);
			stop_run();
		end
	end

	// ##########################################################
	// stimulus
	// ##########################################################

	// columns: bus address, idle gap, expected word.
	task automatic load_requests();
		int          fd;
		int          n;
		int          gap;
		logic [31:0] adr;
		logic [31:0] data;
		string       line;
		fd = $fopen("testbench/flash_read_input.txt", "r");
		if (fd == 0) begin
			$display("could not open testbench/flash_read_input.txt");
			stop_run();
		end
		while (!$feof(fd)) begin
			line = "";
			n = $fgets(line, fd);
			// skip comment and blank lines.
			if ((n > 1) && (line.substr(0, 1) != "//")) begin
				if ($sscanf(line, "%h %d %h", adr, gap, data) == 3) begin
					req_adr.push_back(adr);
					req_gap.push_back(gap);
					req_data.push_back(data);
				end
			end
		end
		$fclose(fd);
	endtask

	// one bus read, called at a rising edge.
	task automatic run_read(input logic [31:0] adr, input logic [31:0] expected);
		int cycles;
		int byte_num;
		wb_adr_i <= adr;
		wb_cyc_i <= 1'b1;
		wb_stb_i <= 1'b1;
		// start edge, previous ack already gone.
		@(posedge sys_clk);
		compare_ack(1'b0, wb_ack_o);
		cycles = 0;
		do begin
			@(posedge sys_clk);
			cycles++;
			// byte address of each read, one edge after it is set.
			if ((cycles <= 4 * (FLASH_WAIT + 1)) && ((cycles % (FLASH_WAIT + 1)) == 1)) begin
				byte_num = cycles / (FLASH_WAIT + 1);
				check_flash_adr({adr[FLASH_ADR_WIDTH-1:2], 2'(byte_num)}, flash_adr);
			end
		end while (wb_ack_o !== 1'b1);
		check_latency(ACK_LATENCY, cycles);
		check_word(expected, wb_dat_o);
	endtask

	initial begin
		int gap_extra;
		sys_clk  = 1'b0;
		sys_rst  = 1'b1;
		wb_adr_i = 32'h0;
		wb_cyc_i = 1'b1;
		wb_stb_i = 1'b1;
		void'($urandom(80853));
		load_requests();
		if (FLASH_SWAP_BYTES) begin
			$display("data file holds words for FLASH_SWAP_BYTES set to 0");
			stop_run();
		end
		if (req_adr.size() == 0) begin
			$display("data file holds no requests");
			stop_run();
		end
		timeout_limit = req_adr.size() * (ACK_LATENCY + 8) + 100;

		// reset with strobes high, no ack.
		@(posedge sys_clk);
		repeat (9) begin
			@(posedge sys_clk);
			compare_ack(1'b0, wb_ack_o);
		end
		sys_rst  <= 1'b0;
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b1;

		// stb without cyc starts nothing.
		repeat (ACK_LATENCY + 4) begin
			@(posedge sys_clk);
			compare_ack(1'b0, wb_ack_o);
		end

		// zero gap keeps the strobes high, back-to-back.
		for (int i = 0; i < req_adr.size(); i++) begin
			if (req_gap[i] > 0) begin
				wb_cyc_i <= 1'b0;
				wb_stb_i <= 1'b0;
				gap_extra = int'($urandom % 4);
				repeat (req_gap[i] + gap_extra) @(posedge sys_clk);
			end
			run_read(req_adr[i], req_data[i]);
		end
		wb_cyc_i <= 1'b0;
		wb_stb_i <= 1'b0;
		@(posedge sys_clk);
		compare_ack(1'b0, wb_ack_o);

		$display("PASS: all tests");
		$finish;
	end

endmodule

/* testbench/flash_read_input.txt */
// bus byte address (hex), idle gap in cycles (dec), expected word (hex)
// gap 0 keeps the strobes high for a back-to-back read
00000000 2 052A4F74
00000004 0 99BEE308
00000100 1 042B4E75
00000103 0 042B4E75
00001234 3 9BBCC1EA
00001238 0 0F50759E
003FFFFC 4 8E69441F
00ABCDE0 1 A8476219
00000010 0 557A9FC4
00020040 2 456A8FB4
00155554 0 7C1B26CD
000000E8 4 8DB2D7FC
0000FF00 1 FAD5B08B
0000FF04 0 66411CF7

/* filelist.f */
common/norflash_pkg.sv
rtl/flash_req_decode.sv
rtl/flash_fetch/flash_fetch_execute.sv
rtl/flash_word_result.sv
rtl/norflash8_top.sv
testbench/flash_model.sv
testbench/norflash8_assert.sv
testbench/tb_norflash8.sv

/* run_sim.sh */
#!/bin/sh
# build and run the NOR flash bridge testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
	-f filelist.f \
	--top-module tb_norflash8 \
	-o sim_norflash8

status=0
output=$(./obj_dir/sim_norflash8 2>&1) || status=$?
printf '%s\n' "$output"

if [ "$status" -eq 0 ] && printf '%s\n' "$output" | grep -q "PASS: all tests"; then
	echo "simulation passed"
	exit 0
fi

echo "simulation failed"
exit 1
